/* hw/tdc_link_pkg.sv */
`default_nettype none

package tdc_link_pkg;

    localparam int NUM_CHANNELS   = 6;
    localparam int PAYLOAD_W      = 32;
    localparam int FIELD_W        = 16;
    localparam int WORD_W         = PAYLOAD_W + FIELD_W;
    localparam int BYTES_PER_WORD = 6;

    typedef logic [PAYLOAD_W-1:0] payload_t;

    // {payload or doubled marker, channel number 1..6}
    typedef logic [WORD_W-1:0] word_t;

    localparam logic [FIELD_W-1:0] LINE_CODE  = 16'h000D;
    localparam logic [FIELD_W-1:0] FRAME_CODE = 16'h000E;

    // Request opcode from a channel front end
    typedef enum logic [1:0] {
        KIND_NONE  = 2'd0,
        KIND_DATA  = 2'd1,
        KIND_LINE  = 2'd2,
        KIND_FRAME = 2'd3
    } word_kind_e;

    typedef enum logic [1:0] {
        TX_IDLE  = 2'd0,
        TX_START = 2'd1,
        TX_BITS  = 2'd2,
        TX_STOP  = 2'd3
    } tx_state_e;

endpackage

`default_nettype wire

/* hw/channel_encoder.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_encoder #(
    parameter int CHANNEL_ID = 1
) (
    input  tdc_link_pkg::payload_t   din,
    input  logic                     wr_en,
    input  logic                     new_line,
    input  logic                     new_frame,
    output tdc_link_pkg::word_kind_e kind,
    output tdc_link_pkg::word_t      word
);

    localparam logic [tdc_link_pkg::FIELD_W-1:0] CHAN_FIELD =
        CHANNEL_ID[tdc_link_pkg::FIELD_W-1:0];

    // Data beats line, line beats frame
    always_comb begin
        if (wr_en) begin
            kind = tdc_link_pkg::KIND_DATA;
            word = {din, CHAN_FIELD};
        end else if (new_line) begin
            kind = tdc_link_pkg::KIND_LINE;
            word = {tdc_link_pkg::LINE_CODE, tdc_link_pkg::LINE_CODE, CHAN_FIELD};
        end else if (new_frame) begin
            kind = tdc_link_pkg::KIND_FRAME;
            word = {tdc_link_pkg::FRAME_CODE, tdc_link_pkg::FRAME_CODE, CHAN_FIELD};
        end else begin
            kind = tdc_link_pkg::KIND_NONE;
            word = {din, CHAN_FIELD}; // don't care
        end
    end

endmodule

`default_nettype wire

/* hw/channel_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module channel_arbiter (
    input  logic                                 clk,
    input  logic                                 rst,
    input  tdc_link_pkg::word_kind_e             kind [tdc_link_pkg::NUM_CHANNELS],
    input  tdc_link_pkg::word_t                  word [tdc_link_pkg::NUM_CHANNELS],
    output logic [tdc_link_pkg::NUM_CHANNELS-1:0] data_done,
    output logic [tdc_link_pkg::NUM_CHANNELS-1:0] line_done,
    output logic [tdc_link_pkg::NUM_CHANNELS-1:0] frame_done,
    output logic                                 fifo_wr_en,
    output tdc_link_pkg::word_t                  fifo_wr_data
);

    logic                grant_valid;
    tdc_link_pkg::word_t grant_word;

    // Lowest index wins, i.e. channel 1 first
    always_comb begin
        grant_valid = 1'b0;
        grant_word  = word[0];
        data_done   = '0;
        line_done   = '0;
        frame_done  = '0;
        for (int i = 0; i < tdc_link_pkg::NUM_CHANNELS; i++) begin
            if (!grant_valid && kind[i] != tdc_link_pkg::KIND_NONE) begin
                grant_valid = 1'b1;
                grant_word  = word[i];
                case (kind[i])
                    tdc_link_pkg::KIND_DATA:  data_done[i]  = 1'b1;
                    tdc_link_pkg::KIND_LINE:  line_done[i]  = 1'b1;
                    tdc_link_pkg::KIND_FRAME: frame_done[i] = 1'b1;
                    default: ;
                endcase
            end
        end
    end

    // Write stage, one cycle after the grant
    always_ff @(posedge clk) begin
        if (rst) begin
            fifo_wr_en <= 1'b0;
        end else begin
            fifo_wr_en <= grant_valid;
        end
    end

    always_ff @(posedge clk) begin
        fifo_wr_data <= grant_word;
    end

endmodule

`default_nettype wire

/* hw/word_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module word_fifo #(
    parameter int FIFO_DEPTH_LOG2 = 10
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                wr_en,
    input  tdc_link_pkg::word_t wr_data,
    input  logic                rd_en,
    output tdc_link_pkg::word_t rd_data,
    output logic                empty,
    output logic                full
);

    localparam int DEPTH = 1 << FIFO_DEPTH_LOG2;

    tdc_link_pkg::word_t mem [DEPTH];

    logic [FIFO_DEPTH_LOG2-1:0] wr_ptr;
    logic [FIFO_DEPTH_LOG2-1:0] rd_ptr;
    logic [FIFO_DEPTH_LOG2:0]   count;  // one extra bit for full
    logic                       do_wr;
    logic                       do_rd;

    assign empty = (count == '0);
    assign full  = (count == DEPTH[FIFO_DEPTH_LOG2:0]);

    // Write to full and read from empty are dropped
    assign do_wr = wr_en && !full;
    assign do_rd = rd_en && !empty;

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_rd) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_wr, do_rd})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    // Registered read port, valid the cycle after rd_en
    always_ff @(posedge clk) begin
        if (do_rd) begin
            rd_data <= mem[rd_ptr];
        end
    end

endmodule

`default_nettype wire

/* hw/serial_word_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module serial_word_tx #(
    parameter int CLK_PER_BIT = 4000000
) (
    input  logic                clk,
    input  logic                rst,
    input  logic                empty,
    input  tdc_link_pkg::word_t rd_data,
    output logic                rd_en,
    output logic                tx,
    output logic                busy
);

    localparam int CNT_W = (CLK_PER_BIT > 1) ? $clog2(CLK_PER_BIT) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CLK_PER_BIT - 1);
    localparam logic [2:0] BYTE_LAST = 3'(tdc_link_pkg::BYTES_PER_WORD - 1);

    tdc_link_pkg::tx_state_e state;
    tdc_link_pkg::word_t     shift_reg;

    logic [CNT_W-1:0] clk_cnt;
    logic [2:0]       bit_idx;
    logic [2:0]       byte_idx;
    logic             rd_en_q;    // word arrives from FIFO this cycle
    logic             bit_end;
    logic             load;
    logic             shift_en;

    // Don't read again while the previous read is still landing
    assign rd_en    = (state == tdc_link_pkg::TX_IDLE) && !empty && !rd_en_q;
    assign load     = (state == tdc_link_pkg::TX_IDLE) && rd_en_q;
    assign bit_end  = (clk_cnt == CNT_LAST);
    assign shift_en = bit_end && ((state == tdc_link_pkg::TX_START) ||
                      (state == tdc_link_pkg::TX_BITS && bit_idx != 3'd7));
    assign busy     = rd_en_q || (state != tdc_link_pkg::TX_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= tdc_link_pkg::TX_IDLE;
            clk_cnt  <= '0;
            bit_idx  <= '0;
            byte_idx <= '0;
            rd_en_q  <= 1'b0;
            tx       <= 1'b1;  // line idles high
        end else begin
            rd_en_q <= rd_en;
            clk_cnt <= (state == tdc_link_pkg::TX_IDLE || bit_end) ? '0 : clk_cnt + 1'b1;
            case (state)
                tdc_link_pkg::TX_IDLE: begin
                    if (load) begin
                        state    <= tdc_link_pkg::TX_START;
                        byte_idx <= '0;
                        tx       <= 1'b0;
                    end
                end
                tdc_link_pkg::TX_START: begin
                    if (bit_end) begin
                        state   <= tdc_link_pkg::TX_BITS;
                        bit_idx <= '0;
                        tx      <= shift_reg[0];
                    end
                end
                tdc_link_pkg::TX_BITS: begin
                    if (bit_end) begin
                        if (bit_idx == 3'd7) begin
                            state <= tdc_link_pkg::TX_STOP;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 1'b1;
                            tx      <= shift_reg[0];
                        end
                    end
                end
                tdc_link_pkg::TX_STOP: begin
                    if (bit_end) begin
                        if (byte_idx == BYTE_LAST) begin
                            state <= tdc_link_pkg::TX_IDLE;
                        end else begin
                            byte_idx <= byte_idx + 1'b1;
                            state    <= tdc_link_pkg::TX_START;
                            tx       <= 1'b0;
                        end
                    end
                end
                default: state <= tdc_link_pkg::TX_IDLE;
            endcase
        end
    end

    // Whole word goes out LSB first, which is low byte first too
    always_ff @(posedge clk) begin
        if (load) begin
            shift_reg <= rd_data;
        end else if (shift_en) begin
            shift_reg <= shift_reg >> 1;
        end
    end

endmodule

`default_nettype wire

/* hw/tdc_link.sv */
`timescale 1ns/1ps
`default_nettype none

module tdc_link #(
    parameter int CLK_PER_BIT     = 4000000,
    parameter int FIFO_DEPTH_LOG2 = 10
) (
    input  logic                                        clk,
    input  logic                                        rst,
    input  tdc_link_pkg::payload_t [tdc_link_pkg::NUM_CHANNELS-1:0] din,
    input  logic [tdc_link_pkg::NUM_CHANNELS-1:0]       wr_en,
    input  logic [tdc_link_pkg::NUM_CHANNELS-1:0]       new_line,
    input  logic [tdc_link_pkg::NUM_CHANNELS-1:0]       new_frame,
    output logic [tdc_link_pkg::NUM_CHANNELS-1:0]       data_done,
    output logic [tdc_link_pkg::NUM_CHANNELS-1:0]       line_done,
    output logic [tdc_link_pkg::NUM_CHANNELS-1:0]       frame_done,
    output logic                                        tx,
    output logic                                        tx_busy
);

    tdc_link_pkg::word_kind_e kind [tdc_link_pkg::NUM_CHANNELS];
    tdc_link_pkg::word_t      word [tdc_link_pkg::NUM_CHANNELS];

    logic                fifo_wr_en;
    tdc_link_pkg::word_t fifo_wr_data;
    logic                fifo_rd_en;
    tdc_link_pkg::word_t fifo_rd_data;
    logic                fifo_empty;

    // Index 0 is channel 1
    for (genvar i = 0; i < tdc_link_pkg::NUM_CHANNELS; i++) begin : g_chan
        channel_encoder #(
            .CHANNEL_ID(i + 1)
        ) u_enc (
            .din       (din[i]),
            .wr_en     (wr_en[i]),
            .new_line  (new_line[i]),
            .new_frame (new_frame[i]),
            .kind      (kind[i]),
            .word      (word[i])
        );
    end

    channel_arbiter u_arb (
        .clk          (clk),
        .rst          (rst),
        .kind         (kind),
        .word         (word),
        .data_done    (data_done),
        .line_done    (line_done),
        .frame_done   (frame_done),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data)
    );

    word_fifo #(
        .FIFO_DEPTH_LOG2(FIFO_DEPTH_LOG2)
    ) u_fifo (
        .clk     (clk),
        .rst     (rst),
        .wr_en   (fifo_wr_en),
        .wr_data (fifo_wr_data),
        .rd_en   (fifo_rd_en),
        .rd_data (fifo_rd_data),
        .empty   (fifo_empty),
        .full    ()             // overflow is dropped inside the FIFO
    );

    serial_word_tx #(
        .CLK_PER_BIT(CLK_PER_BIT)
    ) u_tx (
        .clk     (clk),
        .rst     (rst),
        .empty   (fifo_empty),
        .rd_data (fifo_rd_data),
        .rd_en   (fifo_rd_en),
        .tx      (tx),
        .busy    (tx_busy)
    );

endmodule

`default_nettype wire

/* tb/tdc_link_properties.sv */
`timescale 1ns/1ps
`default_nettype none

module tdc_link_properties #(
    parameter bit TX_SIDE = 1'b0  // 1 for the transmitter checks
) (
    input logic                                    clk,
    input logic                                    rst,
    input logic [3*tdc_link_pkg::NUM_CHANNELS-1:0] done_bits,
    input logic                                    rd_en,
    input tdc_link_pkg::tx_state_e                 state,
    input logic                                    tx
);

    if (!TX_SIDE) begin : g_arb
        // One acknowledge per cycle over all channels and kinds
        a_one_done: assert property (@(posedge clk) disable iff (rst) $onehot0(done_bits))
            else $error("more than one done bit set: %b", done_bits);
    end else begin : g_tx
        a_rd_en_gap: assert property (@(posedge clk) disable iff (rst) rd_en |=> !rd_en)
            else $error("FIFO read issued two cycles in a row");

        a_idle_line: assert property (@(posedge clk) disable iff (rst)
            (state == tdc_link_pkg::TX_IDLE) |-> tx)
            else $error("serial line low while transmitter idle");
    end

endmodule

// Arbiter side, transmitter ports unused there
bind channel_arbiter tdc_link_properties #(.TX_SIDE(1'b0)) u_arb_props (
    .clk       (clk),
    .rst       (rst),
    .done_bits ({data_done, line_done, frame_done}),
    .rd_en     (1'b0),
    .state     (tdc_link_pkg::TX_IDLE),
    .tx        (1'b1)
);

bind serial_word_tx tdc_link_properties #(.TX_SIDE(1'b1)) u_tx_props (
    .clk       (clk),
    .rst       (rst),
    .done_bits ('0),
    .rd_en     (rd_en),
    .state     (state),
    .tx        (tx)
);

`default_nettype wire

/* tb/tb_tdc_link.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_tdc_link;

    localparam int NCH         = tdc_link_pkg::NUM_CHANNELS;
    localparam int FW          = tdc_link_pkg::FIELD_W;
    localparam int BIT_CYCLES  = 4;
    localparam int N_PRIO      = 12;
    localparam int N_CROSS     = 12;
    localparam int N_BURST     = 12;
    localparam int MAX_WORDS   = NCH + 2 * NCH + N_PRIO + N_CROSS + N_BURST + 1;  // last one cut by reset
    localparam int CYCLE_LIMIT = MAX_WORDS * 60 * BIT_CYCLES + 2000;

    typedef logic [NCH-1:0] chan_vec_t;
    typedef tdc_link_pkg::payload_t [NCH-1:0] din_vec_t;

    logic      clk;
    logic      rst;
    din_vec_t  din;
    chan_vec_t wr_en;
    chan_vec_t new_line;
    chan_vec_t new_frame;
    chan_vec_t data_done;
    chan_vec_t line_done;
    chan_vec_t frame_done;
    logic      tx;
    logic      tx_busy;

    tdc_link_pkg::word_t exp_q [$];  // words in grant order

    integer seed = 32'h2e2c5c42;
    int     errors = 0;
    int     checks = 0;
    int     tests_run = 0;
    int     tests_bad = 0;
    int     test_err_start = 0;
    int     cycle_count = 0;
    string  cur_test = "startup";

    tdc_link #(
        .CLK_PER_BIT     (BIT_CYCLES),
        .FIFO_DEPTH_LOG2 (4)
    ) UUT (
        .clk        (clk),
        .rst        (rst),
        .din        (din),
        .wr_en      (wr_en),
        .new_line   (new_line),
        .new_frame  (new_frame),
        .data_done  (data_done),
        .line_done  (line_done),
        .frame_done (frame_done),
        .tx         (tx),
        .tx_busy    (tx_busy)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_word(input string name, input tdc_link_pkg::word_t exp,
                              input tdc_link_pkg::word_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: word expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_done(input string name, input chan_vec_t exp_d, input chan_vec_t exp_l,
                              input chan_vec_t exp_f, input chan_vec_t act_d,
                              input chan_vec_t act_l, input chan_vec_t act_f);
        checks++;
        if ({act_d, act_l, act_f} !== {exp_d, exp_l, exp_f}) begin
            errors++;
            $display("** Error %s: done data/line/frame expected %b/%b/%b, actual %b/%b/%b",
                     name, exp_d, exp_l, exp_f, act_d, act_l, act_f);
        end
    endtask

    task automatic check_level(input string name, input string what, input logic exp,
                               input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error %s: %s expected %b, actual %b", name, what, exp, act);
        end
    endtask

    function automatic logic [FW-1:0] chan_field(input int idx);
        logic [FW-1:0] f;
        f = idx[FW-1:0] + 1'b1;  // channels count from 1
        return f;
    endfunction

    task automatic rand_din(output din_vec_t d);
        for (int i = 0; i < NCH; i++) begin
            d[i] = $random(seed);
        end
    endtask

    // One stimulus cycle; the expected grant comes from the priority rules
    task automatic apply_cycle(input din_vec_t d, input chan_vec_t w, input chan_vec_t l,
                               input chan_vec_t f);
        chan_vec_t           exp_d;
        chan_vec_t           exp_l;
        chan_vec_t           exp_f;
        tdc_link_pkg::word_t exp_w;
        bit                  found;
        @(posedge clk);
        #1;
        din = d;
        wr_en = w;
        new_line = l;
        new_frame = f;
        exp_d = '0;
        exp_l = '0;
        exp_f = '0;
        exp_w = '0;
        found = 1'b0;
        for (int i = 0; i < NCH; i++) begin
            if (!found && (w[i] || l[i] || f[i])) begin
                found = 1'b1;
                if (w[i]) begin
                    exp_d[i] = 1'b1;
                    exp_w = {d[i], chan_field(i)};
                end else if (l[i]) begin
                    exp_l[i] = 1'b1;
                    exp_w = {tdc_link_pkg::LINE_CODE, tdc_link_pkg::LINE_CODE, chan_field(i)};
                end else begin
                    exp_f[i] = 1'b1;
                    exp_w = {tdc_link_pkg::FRAME_CODE, tdc_link_pkg::FRAME_CODE, chan_field(i)};
                end
            end
        end
        if (found) begin
            exp_q.push_back(exp_w);
        end
        #2;
        check_done(cur_test, exp_d, exp_l, exp_f, data_done, line_done, frame_done);
    endtask

    task automatic release_inputs();
        @(posedge clk);
        #1;
        wr_en = '0;
        new_line = '0;
        new_frame = '0;
    endtask

    task automatic wait_drain();
        while (exp_q.size() != 0 || tx_busy !== 1'b0) @(negedge clk);
        repeat (8) begin
            @(negedge clk);
            check_level(cur_test, "idle tx", 1'b1, tx);
            check_level(cur_test, "idle tx_busy", 1'b0, tx_busy);
        end
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_err_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors == test_err_start) begin
            $display("[%s] passed", cur_test);
        end else begin
            tests_bad++;
            $display("[%s] failed with %0d errors", cur_test, errors - test_err_start);
        end
    endtask

    // Rebuilds words from the line, sampling in the middle of each bit
    initial begin : serial_decoder
        tdc_link_pkg::word_t rx_word;
        rx_word = '0;
        forever begin
            for (int k = 0; k < tdc_link_pkg::BYTES_PER_WORD; k++) begin
                @(negedge clk);
                while (tx !== 1'b0) @(negedge clk);
                repeat (BIT_CYCLES / 2) @(negedge clk);
                check_level(cur_test, "start bit", 1'b0, tx);
                check_level(cur_test, "tx_busy during word", 1'b1, tx_busy);
                for (int b = 0; b < 8; b++) begin
                    repeat (BIT_CYCLES) @(negedge clk);
                    rx_word[k*8 + b] = tx;
                end
                repeat (BIT_CYCLES) @(negedge clk);
                check_level(cur_test, "stop bit", 1'b1, tx);
            end
            if (exp_q.size() == 0) begin
                errors++;
                $display("Word %h arrived on the serial line with none expected in %s",
                         rx_word, cur_test);
            end else begin
                check_word(cur_test, exp_q.pop_front(), rx_word);
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
        $display("Something failed");
        $finish;
    end

    initial begin : main_sequence
        din_vec_t  d;
        chan_vec_t one;
        chan_vec_t w;
        int        r;
        int        ch;
        rst = 1'b1;
        din = '0;
        wr_en = '0;
        new_line = '0;
        new_frame = '0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        start_test("single_data");
        for (int i = 0; i < NCH; i++) begin
            rand_din(d);
            apply_cycle(d, chan_vec_t'(1) << i, '0, '0);
        end
        release_inputs();
        wait_drain();
        end_test();

        start_test("markers");
        rand_din(d);
        for (int i = 0; i < NCH; i++) begin
            apply_cycle(d, '0, chan_vec_t'(1) << i, '0);
        end
        for (int i = 0; i < NCH; i++) begin
            apply_cycle(d, '0, '0, chan_vec_t'(1) << i);
        end
        release_inputs();
        wait_drain();
        end_test();

        start_test("in_channel_priority");
        for (int n = 0; n < N_PRIO; n++) begin
            rand_din(d);
            r = $random(seed);
            ch = {1'b0, r[30:0]} % NCH;
            one = chan_vec_t'(1) << ch;
            r = $random(seed);  // strobes independent of the channel pick
            apply_cycle(d, r[0] ? one : '0, r[1] ? one : '0, r[2] ? one : '0);
        end
        release_inputs();
        wait_drain();
        end_test();

        start_test("cross_channel_priority");
        for (int n = 0; n < N_CROSS; n++) begin
            rand_din(d);
            apply_cycle(d, chan_vec_t'($random(seed)), chan_vec_t'($random(seed)),
                        chan_vec_t'($random(seed)));
        end
        release_inputs();
        wait_drain();
        end_test();

        start_test("burst_queueing");
        for (int n = 0; n < N_BURST; n++) begin
            rand_din(d);
            r = $random(seed);
            ch = {1'b0, r[30:0]} % NCH;
            w = chan_vec_t'($random(seed)) | (chan_vec_t'(1) << ch);  // always a grant
            apply_cycle(d, w, chan_vec_t'($random(seed)), chan_vec_t'($random(seed)));
        end
        release_inputs();
        wait_drain();
        end_test();

        start_test("reset_idle");
        rand_din(d);
        apply_cycle(d, chan_vec_t'(1), '0, '0);
        release_inputs();
        while (tx_busy !== 1'b1) @(negedge clk);
        repeat (5 * BIT_CYCLES) @(negedge clk);  // partway into the first byte
        @(posedge clk);
        #1;
        rst = 1'b1;
        exp_q.delete();  // word in flight is lost to the reset
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;
        repeat (50) begin
            @(negedge clk);
            check_level(cur_test, "tx after reset", 1'b1, tx);
            check_level(cur_test, "tx_busy after reset", 1'b0, tx_busy);
            check_done(cur_test, '0, '0, '0, data_done, line_done, frame_done);
        end
        end_test();

        $display("Tests run %0d, failing %0d, checks %0d, errors %0d",
                 tests_run, tests_bad, checks, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tdc_link.f */
hw/tdc_link_pkg.sv
hw/channel_encoder.sv
hw/channel_arbiter.sv
hw/word_fifo.sv
hw/serial_word_tx.sv
hw/tdc_link.sv
tb/tdc_link_properties.sv
tb/tb_tdc_link.sv

/* Makefile */
TOP := tb_tdc_link

all: run

run:
	verilator --binary --timing --assert --top-module $(TOP) -f tdc_link.f -Mdir obj_dir -o V$(TOP)
	-./obj_dir/V$(TOP) > sim.log 2>&1
	@cat sim.log
	@if grep -q "Something failed" sim.log; then echo "RESULT: FAIL"; exit 1; fi
	@if ! grep -q "Everything OK" sim.log; then echo "RESULT: FAIL (no result line)"; exit 1; fi
	@echo "RESULT: PASS"

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f tdc_link.f

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
